//--- Bender.yml
package:
  name: mist_glue

sources:
  - rtl/mist_glue_pkg.sv
  - rtl/clken_gen.sv
  - rtl/pll_reconfig_seq.sv
  - rtl/back_porch_blank.sv
  - rtl/loader_bridge.sv
  - rtl/mist_glue_top.sv
  - target: test
    files:
      - tests/mist_glue_assertions.sv
      - tests/tb_mist_glue.sv

//--- files.f
rtl/mist_glue_pkg.sv
rtl/clken_gen.sv
rtl/pll_reconfig_seq.sv
rtl/back_porch_blank.sv
rtl/loader_bridge.sv
rtl/mist_glue_top.sv
tests/mist_glue_assertions.sv
tests/tb_mist_glue.sv

//--- rtl/back_porch_blank.sv
`default_nettype none

module back_porch_blank (
	input  wire                        clk_sys,
	input  wire                        reset_i,
	input  wire                        ce_pix_i,
	input  wire mist_glue_pkg::pix_sel_t pix_sel_i,
	input  wire mist_glue_pkg::video_t   video_i,
	output mist_glue_pkg::video_t        video_o
);

	logic [7:0]            porch_cnt;
	logic                  tv_mode;
	logic                  porch_done; // counter saturated, window is over
	mist_glue_pkg::video_t video_q;

	// tv profiles blank 256 cycles, the others 64
	assign tv_mode    = (pix_sel_i[0] == pix_sel_i[1]);
	assign porch_done = tv_mode ? (&porch_cnt) : (&porch_cnt[5:0]);

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			porch_cnt <= '0;
		end else if (!video_q.hs) begin
			porch_cnt <= '0; // held clear through the sync pulse
		end else if (!porch_done) begin
			porch_cnt <= porch_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			video_q <= '0;
		end else if (ce_pix_i) begin
			video_q.hs <= video_i.hs;
			video_q.vs <= video_i.vs;
			if (porch_done) begin
				video_q.r <= video_i.r;
				video_q.g <= video_i.g;
				video_q.b <= video_i.b;
			end else begin
				video_q.r <= '0; // forced black
				video_q.g <= '0;
				video_q.b <= '0;
			end
		end
	end

	assign video_o = video_q;

endmodule

`default_nettype wire

//--- rtl/clken_gen.sv
`default_nettype none

module clken_gen #(
	parameter int CLKEN_DIV = 20 // multiple of 4
) (
	input  wire  clk_sys,
	input  wire  reset_i,
	output logic clk2m_en_o,
	output logic clk8m_en_o
);

	localparam int CNT_W   = $clog2(CLKEN_DIV);
	localparam int QUARTER = CLKEN_DIV / 4;

	logic [CNT_W-1:0] div_cnt;
	logic             at_zero;
	logic             at_quarter;

	assign at_zero    = (div_cnt == '0);
	assign at_quarter = at_zero
		|| (div_cnt == CNT_W'(QUARTER))
		|| (div_cnt == CNT_W'(2 * QUARTER))
		|| (div_cnt == CNT_W'(3 * QUARTER));

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			div_cnt    <= '0;
			clk2m_en_o <= 1'b0;
			clk8m_en_o <= 1'b0;
		end else begin
			if (div_cnt == CNT_W'(CLKEN_DIV - 1))
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
			clk2m_en_o <= at_zero;    // once per full count
			clk8m_en_o <= at_quarter; // four times, first one with 2m
		end
	end

endmodule

`default_nettype wire

//--- rtl/loader_bridge.sv
`default_nettype none

module loader_bridge (
	input  wire                          clk_sys,
	input  wire                          reset_i,
	input  wire                          downloading_i,
	input  wire mist_glue_pkg::dio_index_t dio_index_i,
	input  wire                          loader_we_i,
	input  wire mist_glue_pkg::load_addr_t loader_addr_i,
	input  wire mist_glue_pkg::byte_t      loader_data_i,
	input  wire mist_glue_pkg::mem_req_t   core_req_i,
	output logic                         core_ack_o,
	output mist_glue_pkg::mem_req_t        mem_req_o,
	input  wire                          mem_ack_i,
	input  wire                          ram_ready_i,
	input  wire                          reset_button_i,
	output logic                         core_reset_o
);

	logic                     loader_mode;
	logic                     loader_mode_q;
	logic                     loader_stb;
	logic                     rom_ready;
	mist_glue_pkg::byte_sel_t loader_sel;

	assign loader_mode = downloading_i
		&& (dio_index_i == mist_glue_pkg::ROM_INDEX_A
		|| dio_index_i == mist_glue_pkg::ROM_INDEX_B);

	// lane 0 for address 0
	assign loader_sel = mist_glue_pkg::byte_sel_t'(1) << loader_addr_i[1:0];

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			loader_stb    <= 1'b0;
			loader_mode_q <= 1'b0;
			rom_ready     <= 1'b0;
		end else begin
			loader_mode_q <= loader_mode;
			if (loader_mode_q && !loader_mode)
				rom_ready <= 1'b1; // download just finished
			if (loader_mode && loader_we_i)
				loader_stb <= 1'b1;
			else if (mem_ack_i)
				loader_stb <= 1'b0; // held until the memory takes it
		end
	end

	always_comb begin
		if (loader_mode) begin
			mem_req_o.cyc = loader_stb;
			mem_req_o.stb = loader_stb;
			mem_req_o.we  = 1'b1;
			mem_req_o.sel = loader_sel;
			mem_req_o.adr = {loader_addr_i[23:2], 2'b00};
			mem_req_o.dat = {4{loader_data_i}}; // same byte on every lane
			core_ack_o    = 1'b0; // core is locked out
		end else begin
			mem_req_o        = core_req_i;
			mem_req_o.cyc    = core_req_i.stb;
			mem_req_o.adr    = {core_req_i.adr[23:2], 2'b00};
			core_ack_o       = mem_ack_i;
		end
	end

	// core held until sdram is up and the rom image is in
	assign core_reset_o = !ram_ready_i || !rom_ready || reset_button_i;

endmodule

`default_nettype wire

//--- rtl/mist_glue_pkg.sv
`default_nettype none

package mist_glue_pkg;

	// bits per colour channel of the core video
	localparam int COLOR_W = 4;

	typedef logic [7:0]  byte_t;       // loader data byte
	typedef logic [31:0] word_t;       // memory bus data word
	typedef logic [3:0]  byte_sel_t;   // byte lane select
	typedef logic [23:0] load_addr_t;  // loader byte address
	typedef logic [7:0]  dio_index_t;  // loader channel index

	// loader indices that carry a ROM image
	localparam dio_index_t ROM_INDEX_A = 8'd1;
	localparam dio_index_t ROM_INDEX_B = 8'd2;

	// pixel base clock profile
	// 00/11 tv 24 MHz, 01 vga 25 MHz, 10 36 MHz
	typedef logic [1:0] pix_sel_t;

	localparam pix_sel_t PIX_SEL_RESET = 2'b10;

	// memory bus request, core side and memory side alike
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		byte_sel_t  sel;
		load_addr_t adr;
		word_t      dat;
	} mem_req_t;

	typedef struct packed {
		logic               hs;
		logic               vs;
		logic [COLOR_W-1:0] r;
		logic [COLOR_W-1:0] g;
		logic [COLOR_W-1:0] b;
	} video_t;

	// pll reconfiguration sequencer
	typedef enum logic [1:0] {
		RCF_IDLE,
		RCF_LOAD,
		RCF_WAIT_IDLE,
		RCF_RUN
	} reconfig_state_e;

endpackage

`default_nettype wire

//--- rtl/mist_glue_top.sv
`default_nettype none

module mist_glue_top #(
	parameter int CLKEN_DIV        = 20,
	parameter int RECONFIG_TIMEOUT = 1000
) (
	input  wire                          clk_sys,
	input  wire                          reset_i,
	output logic                         clk2m_en_o,
	output logic                         clk8m_en_o,
	input  wire mist_glue_pkg::pix_sel_t   pix_sel_i,
	input  wire                          reconfig_busy_i,
	output logic                         vid_clk_ena_o,
	output logic                         write_from_rom_o,
	output logic                         reconfig_o,
	output logic                         reconfig_reset_o,
	input  wire                          ce_pix_i,
	input  wire mist_glue_pkg::video_t     video_i,
	output mist_glue_pkg::video_t          video_o,
	input  wire                          downloading_i,
	input  wire mist_glue_pkg::dio_index_t dio_index_i,
	input  wire                          loader_we_i,
	input  wire mist_glue_pkg::load_addr_t loader_addr_i,
	input  wire mist_glue_pkg::byte_t      loader_data_i,
	input  wire mist_glue_pkg::mem_req_t   core_req_i,
	output logic                         core_ack_o,
	output mist_glue_pkg::mem_req_t        mem_req_o,
	input  wire                          mem_ack_i,
	input  wire                          ram_ready_i,
	input  wire                          reset_button_i,
	output logic                         core_reset_o
);

	clken_gen #(
		.CLKEN_DIV (CLKEN_DIV)
	) u_clken_gen (
		.clk_sys    (clk_sys),
		.reset_i    (reset_i),
		.clk2m_en_o (clk2m_en_o),
		.clk8m_en_o (clk8m_en_o)
	);

	pll_reconfig_seq #(
		.RECONFIG_TIMEOUT (RECONFIG_TIMEOUT)
	) u_pll_reconfig_seq (
		.clk_sys          (clk_sys),
		.reset_i          (reset_i),
		.pix_sel_i        (pix_sel_i),
		.reconfig_busy_i  (reconfig_busy_i),
		.vid_clk_ena_o    (vid_clk_ena_o),
		.write_from_rom_o (write_from_rom_o),
		.reconfig_o       (reconfig_o),
		.reconfig_reset_o (reconfig_reset_o)
	);

	// same profile select decides the porch length
	back_porch_blank u_back_porch_blank (
		.clk_sys   (clk_sys),
		.reset_i   (reset_i),
		.ce_pix_i  (ce_pix_i),
		.pix_sel_i (pix_sel_i),
		.video_i   (video_i),
		.video_o   (video_o)
	);

	loader_bridge u_loader_bridge (
		.clk_sys        (clk_sys),
		.reset_i        (reset_i),
		.downloading_i  (downloading_i),
		.dio_index_i    (dio_index_i),
		.loader_we_i    (loader_we_i),
		.loader_addr_i  (loader_addr_i),
		.loader_data_i  (loader_data_i),
		.core_req_i     (core_req_i),
		.core_ack_o     (core_ack_o),
		.mem_req_o      (mem_req_o),
		.mem_ack_i      (mem_ack_i),
		.ram_ready_i    (ram_ready_i),
		.reset_button_i (reset_button_i),
		.core_reset_o   (core_reset_o)
	);

endmodule

`default_nettype wire

//--- rtl/pll_reconfig_seq.sv
`default_nettype none

module pll_reconfig_seq #(
	parameter int RECONFIG_TIMEOUT = 1000
) (
	input  wire                       clk_sys,
	input  wire                       reset_i,
	input  wire mist_glue_pkg::pix_sel_t pix_sel_i,
	input  wire                       reconfig_busy_i,
	output logic                      vid_clk_ena_o,
	output logic                      write_from_rom_o,
	output logic                      reconfig_o,
	output logic                      reconfig_reset_o
);

	localparam int TMO_W = $clog2(RECONFIG_TIMEOUT + 1);

	mist_glue_pkg::reconfig_state_e state;
	mist_glue_pkg::pix_sel_t        pix_sel_q; // profile the pll was last set to
	logic [TMO_W-1:0]               timeout_cnt;

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			state            <= mist_glue_pkg::RCF_IDLE;
			pix_sel_q        <= mist_glue_pkg::PIX_SEL_RESET;
			timeout_cnt      <= '0;
			vid_clk_ena_o    <= 1'b1;
			write_from_rom_o <= 1'b0;
			reconfig_o       <= 1'b0;
			reconfig_reset_o <= 1'b0;
		end else begin
			// pulse outputs, high for a single cycle when set below
			write_from_rom_o <= 1'b0;
			reconfig_o       <= 1'b0;
			reconfig_reset_o <= 1'b0;

			case (state)
				mist_glue_pkg::RCF_IDLE: begin
					vid_clk_ena_o <= 1'b1;
					pix_sel_q     <= pix_sel_i;
					if (pix_sel_q != pix_sel_i) begin
						// stop video clocks while the pll moves
						vid_clk_ena_o    <= 1'b0;
						write_from_rom_o <= 1'b1;
						state            <= mist_glue_pkg::RCF_LOAD;
					end
				end

				mist_glue_pkg::RCF_LOAD: begin
					state <= mist_glue_pkg::RCF_WAIT_IDLE; // one cycle gap
				end

				mist_glue_pkg::RCF_WAIT_IDLE: begin
					if (!reconfig_busy_i) begin
						reconfig_o  <= 1'b1;
						timeout_cnt <= TMO_W'(RECONFIG_TIMEOUT);
						state       <= mist_glue_pkg::RCF_RUN;
					end
				end

				mist_glue_pkg::RCF_RUN: begin
					timeout_cnt <= timeout_cnt - 1'b1;
					if (timeout_cnt == TMO_W'(1)) begin
						// busy never dropped, kick the reconfig block
						reconfig_reset_o <= 1'b1;
						state            <= mist_glue_pkg::RCF_IDLE;
					end
					// busy is not valid yet in the pulse cycle
					if (!reconfig_o && !reconfig_busy_i)
						state <= mist_glue_pkg::RCF_IDLE;
				end

				default: state <= mist_glue_pkg::RCF_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- tests/mist_glue_assertions.sv
`default_nettype none

module mist_glue_assertions (
	input wire                           clk_sys,
	input wire                           reset_i,
	input wire                           loader_mode,
	input wire                           core_ack,
	input wire mist_glue_pkg::byte_sel_t sel,
	input wire                           write_from_rom,
	input wire                           reconfig
);

	int fail_count;

	// core is locked out while the loader owns the bus
	core_ack_locked: assert property (@(posedge clk_sys) disable iff (reset_i)
		loader_mode |-> !core_ack)
		else begin
			$error("core ack high while the loader owns the bus");
			fail_count++;
		end

	sel_onehot: assert property (@(posedge clk_sys) disable iff (reset_i)
		loader_mode |-> $onehot(sel))
		else begin
			$error("byte select not one-hot in loader mode");
			fail_count++;
		end

	pulses_apart: assert property (@(posedge clk_sys) disable iff (reset_i)
		!(write_from_rom && reconfig))
		else begin
			$error("write_from_rom and reconfig high in the same cycle");
			fail_count++;
		end

endmodule

bind loader_bridge mist_glue_assertions u_bridge_checks (
	.clk_sys        (clk_sys),
	.reset_i        (reset_i),
	.loader_mode    (loader_mode),
	.core_ack       (core_ack_o),
	.sel            (mem_req_o.sel),
	.write_from_rom (1'b0),
	.reconfig       (1'b0)
);

bind pll_reconfig_seq mist_glue_assertions u_seq_checks (
	.clk_sys        (clk_sys),
	.reset_i        (reset_i),
	.loader_mode    (1'b0),
	.core_ack       (1'b0),
	.sel            (4'b0001),
	.write_from_rom (write_from_rom_o),
	.reconfig       (reconfig_o)
);

`default_nettype wire

//--- tests/tb_mist_glue.sv
`default_nettype none

module tb_mist_glue;

	localparam int CLK_PERIOD = 40;
	// reset, the six tests in run order, then margin
	localparam int WATCHDOG_CYCLES = 10 + 210 + 80 + 150 + 90 + 45 + 360 + 250;

	logic                      clk_sys;
	logic                      reset_i;
	logic                      clk2m_en_o, clk8m_en_o;
	mist_glue_pkg::pix_sel_t   pix_sel_i;
	logic                      reconfig_busy_i;
	logic                      vid_clk_ena_o, write_from_rom_o, reconfig_o, reconfig_reset_o;
	logic                      ce_pix_i;
	mist_glue_pkg::video_t     video_i, video_o;
	logic                      downloading_i, loader_we_i;
	mist_glue_pkg::dio_index_t dio_index_i;
	mist_glue_pkg::load_addr_t loader_addr_i;
	mist_glue_pkg::byte_t      loader_data_i;
	mist_glue_pkg::mem_req_t   core_req_i, mem_req_o;
	logic                      core_ack_o, mem_ack_i, ram_ready_i, reset_button_i, core_reset_o;

	logic [31:0] lfsr;
	bit          busy_stuck; // busy never released
	string       cur_test;
	int          test_errors, total_errors, tests_run, tests_failed;
	int          assert_fails;
	int          n_wfr, n_rcf, n_rst, wfr_at, rcf_at, rst_at;
	bit          ena_dropped, ena_back;

	mist_glue_top #(.RECONFIG_TIMEOUT(16)) dut (.*);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr); // one step per bit
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic expect_equal(input string what, input logic [63:0] exp,
			input logic [63:0] act);
		assert (act === exp) else begin
			$display("mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("%s: %s", cur_test, msg);
		test_errors++;
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			$display("%s: ok", cur_test);
		end else begin
			$display("%s: %0d errors", cur_test, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		tests_run++;
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// memory side, ack 1 to 3 cycles after a strobe
	initial begin : mem_responder
		int unsigned delay;
		forever begin
			@(posedge clk_sys);
			if (mem_req_o.stb) begin
				delay = 1 + rand_bits(2) % 3;
				repeat (delay - 1) @(posedge clk_sys);
				mem_ack_i <= 1'b1;
				@(posedge clk_sys);
				mem_ack_i <= 1'b0;
			end
		end
	end

	initial begin : busy_responder
		int unsigned len;
		forever begin
			@(posedge clk_sys);
			if (reconfig_o) begin
				reconfig_busy_i <= 1'b1;
				if (busy_stuck) begin
					wait (!busy_stuck);
					@(posedge clk_sys);
				end else begin
					len = 2 + rand_bits(3) % 7; // 2 to 8 cycles
					repeat (len) @(posedge clk_sys);
				end
				reconfig_busy_i <= 1'b0;
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired, run still busy after %0d cycles", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	task automatic clock_enables();
		int last_2m;
		int last_8m;
		int n_2m;
		begin_test("clock_enables");
		last_2m = -1;
		last_8m = -1;
		n_2m = 0;
		for (int i = 0; i < 200; i++) begin
			@(negedge clk_sys);
			if (clk2m_en_o) begin
				if (last_2m >= 0)
					expect_equal("2 MHz spacing", 20, i - last_2m);
				expect_equal("8 MHz with 2 MHz", 1, clk8m_en_o);
				last_2m = i;
				n_2m++;
			end
			if (clk8m_en_o) begin
				if (last_8m >= 0)
					expect_equal("8 MHz spacing", 5, i - last_8m);
				last_8m = i;
			end
		end
		expect_equal("2 MHz pulse count", 10, n_2m);
		end_test();
	endtask

	task automatic core_passthrough();
		mist_glue_pkg::mem_req_t req;
		mist_glue_pkg::mem_req_t exp;
		bit acked;
		begin_test("core_passthrough");
		for (int n = 0; n < 8; n++) begin
			req.cyc = 1'b0; // cyc must come from stb
			req.stb = 1'b1;
			req.we = rand_bits(1);
			req.sel = rand_bits(4);
			req.adr = rand_bits(24);
			req.dat = rand_bits(32);
			exp = req;
			exp.cyc = 1'b1;
			exp.adr[1:0] = 2'b00;
			@(posedge clk_sys);
			downloading_i <= (n >= 4); // index 3 is no rom download
			dio_index_i <= 8'd3;
			core_req_i <= req;
			acked = 1'b0;
			for (int i = 0; i < 8 && !acked; i++) begin
				@(negedge clk_sys);
				expect_equal("memory request", exp, mem_req_o);
				expect_equal("core ack", mem_ack_i, core_ack_o);
				acked = core_ack_o;
			end
			assert (acked) else report_error("core request was never acknowledged");
			@(posedge clk_sys);
			core_req_i <= '0;
		end
		downloading_i <= 1'b0;
		end_test();
	endtask

	task automatic rom_download();
		mist_glue_pkg::mem_req_t    exp;
		mist_glue_pkg::load_addr_t  addr;
		mist_glue_pkg::byte_t       data;
		bit seen;
		bit acked;
		bit done;
		begin_test("rom_download");
		@(posedge clk_sys);
		downloading_i <= 1'b1;
		dio_index_i <= mist_glue_pkg::ROM_INDEX_A;
		for (int n = 0; n < 8; n++) begin
			addr = rand_bits(24);
			data = rand_bits(8);
			case (addr[1:0])
				2'd0: exp.sel = 4'b0001;
				2'd1: exp.sel = 4'b0010;
				2'd2: exp.sel = 4'b0100;
				default: exp.sel = 4'b1000;
			endcase
			exp.cyc = 1'b1;
			exp.stb = 1'b1;
			exp.we = 1'b1;
			exp.adr = {addr[23:2], 2'b00};
			exp.dat = {data, data, data, data};
			@(posedge clk_sys);
			loader_addr_i <= addr;
			loader_data_i <= data;
			loader_we_i <= 1'b1;
			@(posedge clk_sys);
			loader_we_i <= 1'b0;
			seen = 1'b0;
			acked = 1'b0;
			done = 1'b0;
			for (int i = 0; i < 10 && !done; i++) begin
				@(negedge clk_sys);
				expect_equal("core ack", 0, core_ack_o);
				expect_equal("core reset in download", 1, core_reset_o);
				if (mem_req_o.stb) begin
					expect_equal("memory request", exp, mem_req_o);
					seen = 1'b1;
					acked = acked || mem_ack_i;
				end else if (seen) begin
					assert (acked) else report_error("strobe dropped before the acknowledge");
					done = 1'b1;
				end
			end
			assert (done) else report_error("loader write did not complete");
		end
		@(posedge clk_sys);
		downloading_i <= 1'b0;
		done = 1'b0;
		for (int i = 0; i < 4 && !done; i++) begin
			@(negedge clk_sys);
			done = !core_reset_o;
		end
		assert (done) else report_error("core reset stayed high after the download ended");
		@(posedge clk_sys);
		reset_button_i <= 1'b1;
		@(negedge clk_sys);
		expect_equal("core reset, button pressed", 1, core_reset_o);
		@(posedge clk_sys);
		reset_button_i <= 1'b0;
		@(negedge clk_sys);
		expect_equal("core reset, button released", 0, core_reset_o);
		end_test();
	endtask

	// drive a profile and log the sequencer pulses
	task automatic watch_reconfig(input mist_glue_pkg::pix_sel_t sel);
		n_wfr = 0;
		n_rcf = 0;
		n_rst = 0;
		ena_dropped = 1'b0;
		ena_back = 1'b0;
		@(posedge clk_sys);
		pix_sel_i <= sel;
		for (int i = 0; i < 40 && !ena_back; i++) begin
			@(negedge clk_sys);
			if (write_from_rom_o) begin
				n_wfr++;
				wfr_at = i;
			end
			if (reconfig_o) begin
				n_rcf++;
				rcf_at = i;
			end
			if (reconfig_reset_o) begin
				n_rst++;
				rst_at = i;
			end
			if (!vid_clk_ena_o)
				ena_dropped = 1'b1;
			else if (ena_dropped)
				ena_back = 1'b1;
		end
	endtask

	task automatic profile_change();
		begin_test("profile_change");
		watch_reconfig(2'b01);
		assert (ena_dropped && ena_back)
			else report_error("video clocks did not drop and come back");
		expect_equal("write_from_rom pulses", 1, n_wfr);
		expect_equal("reconfig pulses", 1, n_rcf);
		expect_equal("reconfig_reset pulses", 0, n_rst);
		assert (n_wfr != 1 || n_rcf != 1 || wfr_at < rcf_at)
			else report_error("reconfig pulse did not follow write_from_rom");
		expect_equal("busy at clock return", 0, reconfig_busy_i);
		watch_reconfig(2'b01); // same profile again
		expect_equal("clock drop, same profile", 0, ena_dropped);
		expect_equal("pulses, same profile", 0, n_wfr + n_rcf + n_rst);
		end_test();
	endtask

	task automatic stuck_busy();
		begin_test("stuck_busy");
		busy_stuck = 1'b1;
		watch_reconfig(2'b11);
		expect_equal("reconfig pulses", 1, n_rcf);
		expect_equal("reconfig_reset pulses", 1, n_rst);
		assert (n_rst != 1 || n_rcf != 1 || (rst_at > rcf_at && rst_at - rcf_at <= 16))
			else report_error("reconfig_reset not within 16 cycles of reconfig");
		assert (ena_back) else report_error("video clocks did not return after the timeout");
		busy_stuck = 1'b0;
		repeat (2) @(posedge clk_sys);
		end_test();
	endtask

	task automatic porch_window(input mist_glue_pkg::pix_sel_t sel, input int zero_cycles,
			input int color_after);
		mist_glue_pkg::video_t vin;
		vin.hs = 1'b0;
		vin.vs = 1'b1;
		vin.r = rand_bits(4) | 1; // never black
		vin.g = rand_bits(4);
		vin.b = rand_bits(4);
		@(posedge clk_sys);
		pix_sel_i <= sel;
		ce_pix_i <= 1'b1;
		video_i <= vin;
		repeat (4) @(posedge clk_sys);
		vin.hs = 1'b1;
		video_i <= vin;
		for (int k = 1; k <= color_after + 8; k++) begin
			@(negedge clk_sys);
			if (k == 1)
				expect_equal("syncs out", 2'b01, {video_o.hs, video_o.vs});
			else
				expect_equal("syncs out", 2'b11, {video_o.hs, video_o.vs});
			if (k <= zero_cycles)
				expect_equal("colour in window", 0, {video_o.r, video_o.g, video_o.b});
			else if (k > color_after)
				expect_equal("colour after window", {vin.r, vin.g, vin.b},
					{video_o.r, video_o.g, video_o.b});
		end
	endtask

	task automatic back_porch();
		begin_test("back_porch");
		porch_window(2'b01, 60, 70);
		porch_window(2'b00, 250, 262);
		end_test();
	endtask

	initial begin
		lfsr = 32'd74225;
		reset_i = 1'b1;
		pix_sel_i = mist_glue_pkg::PIX_SEL_RESET;
		reconfig_busy_i = 1'b0;
		ce_pix_i = 1'b0;
		video_i = '0;
		downloading_i = 1'b0;
		dio_index_i = '0;
		loader_we_i = 1'b0;
		loader_addr_i = '0;
		loader_data_i = '0;
		core_req_i = '0;
		mem_ack_i = 1'b0;
		ram_ready_i = 1'b1;
		reset_button_i = 1'b0;
		repeat (10) @(posedge clk_sys);
		reset_i <= 1'b0;
		clock_enables();
		core_passthrough();
		rom_download();
		profile_change();
		stuck_busy();
		back_porch();
		assert_fails = dut.u_loader_bridge.u_bridge_checks.fail_count
			+ dut.u_pll_reconfig_seq.u_seq_checks.fail_count;
		$display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
			tests_run, tests_failed, total_errors, assert_fails);
		if (total_errors == 0 && assert_fails == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
